// File: Makefile
SOURCES := $(shell cat compile.f)

all: run

obj_dir/Vtb_fetch_top: compile.f $(SOURCES)
	verilator --binary --timing -j 0 -f compile.f --top-module tb_fetch_top -o Vtb_fetch_top

run: obj_dir/Vtb_fetch_top
	./obj_dir/Vtb_fetch_top 2>&1 | tee sim.log
	grep -q "^Testbench passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: compile.f
hdl/fetch_pkg.sv
hdl/ifu.sv
hdl/inst_mem.sv
hdl/inst_decoder.sv
hdl/fetch_top.sv
verification/tb_fetch_top.sv

// File: hdl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  localparam logic [31:0] reset_vector = 32'h8000_0000;
  localparam int          mem_words    = 512;
  localparam int          mem_idx_w    = $clog2(mem_words);
  localparam logic [31:0] ebreak_inst  = 32'h0010_0073;

  // rv32 base opcodes in bits 6:0
  localparam logic [6:0] opc_lui     = 7'b0110111;
  localparam logic [6:0] opc_auipc   = 7'b0010111;
  localparam logic [6:0] opc_jal     = 7'b1101111;
  localparam logic [6:0] opc_jalr    = 7'b1100111;
  localparam logic [6:0] opc_branch  = 7'b1100011;
  localparam logic [6:0] opc_load    = 7'b0000011;
  localparam logic [6:0] opc_store   = 7'b0100011;
  localparam logic [6:0] opc_alu_imm = 7'b0010011;
  localparam logic [6:0] opc_alu     = 7'b0110011;
  localparam logic [6:0] opc_system  = 7'b1110011;

  typedef enum logic [3:0] {
    op_lui, op_auipc, op_jal, op_jalr, op_branch, op_load,
    op_store, op_alu_imm, op_alu, op_system, op_ebreak, op_illegal
  } inst_op_e;

  typedef enum logic [1:0] {
    perf_none, perf_wait_mem, perf_wait_down
  } perf_state_e;

  // axi-style read address with the size fixed at 4 bytes
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
  } ar_chan_t;

  typedef struct packed {
    logic        valid;
    logic [63:0] data;
  } r_chan_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
  } fetch_pkt_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
    inst_op_e    op;
    logic [31:0] imm;
  } dec_pkt_t;

  typedef struct packed {
    logic [31:0] fetches;
    logic [31:0] wait_mem;
    logic [31:0] wait_down;
  } perf_cnt_t;

  typedef struct packed {
    logic                 we;
    logic [mem_idx_w-1:0] idx;
    logic [63:0]          data;
  } prog_wr_t;

endpackage

`default_nettype wire

// File: hdl/fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_top
  import fetch_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     rstn,
  input  wire prog_wr_t prog,
  input  wire logic     dec_ready,
  output logic          dec_valid,
  output dec_pkt_t      dec,
  output logic          halt,
  output perf_cnt_t     perf
);

  ar_chan_t    ar;
  logic        ar_ready;
  r_chan_t     r;
  logic        r_ready;
  logic        fetch_valid;
  logic        fetch_ready;
  fetch_pkt_t  fetch;
  logic [31:0] npc;

  ifu i_ifu (
    .clk         (clk),
    .rstn        (rstn),
    .npc         (npc),
    .fetch_ready (fetch_ready),
    .r           (r),
    .ar_ready    (ar_ready),
    .halt        (halt),
    .ar          (ar),
    .r_ready     (r_ready),
    .fetch_valid (fetch_valid),
    .fetch       (fetch),
    .perf        (perf)
  );

  inst_mem i_inst_mem (
    .clk      (clk),
    .rstn     (rstn),
    .prog     (prog),
    .ar       (ar),
    .r_ready  (r_ready),
    .ar_ready (ar_ready),
    .r        (r)
  );

  inst_decoder i_inst_decoder (
    .clk         (clk),
    .rstn        (rstn),
    .fetch_valid (fetch_valid),
    .fetch       (fetch),
    .dec_ready   (dec_ready),
    .fetch_ready (fetch_ready),
    .npc         (npc),
    .dec_valid   (dec_valid),
    .dec         (dec),
    .halt        (halt)
  );

endmodule

`default_nettype wire

// File: hdl/ifu.sv
`timescale 1ns/1ns
`default_nettype none

module ifu
  import fetch_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rstn,
  input  wire logic [31:0] npc,
  input  wire logic        fetch_ready,
  input  wire r_chan_t     r,
  input  wire logic        ar_ready,
  input  wire logic        halt,
  output ar_chan_t         ar,
  output logic             r_ready,
  output logic             fetch_valid,
  output fetch_pkt_t       fetch,
  output perf_cnt_t        perf
);

  logic        req_q;
  logic [31:0] addr_q;
  logic [31:0] pc_q;
  logic        ar_hs;
  logic        r_hs;
  perf_state_e perf_st;

  // no new request once the decoder has seen ebreak
  assign ar = '{valid: req_q & ~halt, addr: addr_q};

  assign ar_hs = ar.valid & ar_ready;
  assign r_hs  = r.valid & r_ready;

  // memory beat goes straight to decode
  assign fetch_valid = r.valid;
  assign r_ready     = fetch_ready;

  assign fetch.pc   = pc_q;
  assign fetch.inst = addr_q[2] ? r.data[63:32] : r.data[31:0];

  always_ff @(posedge clk) begin
    if (!rstn) begin
      req_q  <= 1'b1;
      addr_q <= reset_vector;
      pc_q   <= reset_vector;
    end else begin
      if (ar_hs) begin
        req_q <= 1'b0;
        pc_q  <= addr_q;
      end
      if (r_hs) begin
        req_q  <= 1'b1;
        addr_q <= npc;
      end
    end
  end

  // perf state and counters
  always_ff @(posedge clk) begin
    if (!rstn) begin
      perf_st <= perf_none;
      perf    <= '0;
    end else begin
      if (ar_hs) begin
        perf.fetches <= perf.fetches + 32'd1;
      end
      case (perf_st)
        perf_wait_mem: begin
          perf.wait_mem <= perf.wait_mem + 32'd1;
          if (r_hs) begin
            perf_st <= perf_wait_down;
          end
        end
        perf_wait_down: begin
          perf.wait_down <= perf.wait_down + 32'd1;
          if (ar_hs) begin
            perf_st <= perf_wait_mem;
          end
        end
        default: begin
          if (ar_hs) begin
            perf_st <= perf_wait_mem;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/inst_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module inst_decoder
  import fetch_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rstn,
  input  wire logic       fetch_valid,
  input  wire fetch_pkt_t fetch,
  input  wire logic       dec_ready,
  output logic            fetch_ready,
  output logic [31:0]     npc,
  output logic            dec_valid,
  output dec_pkt_t        dec,
  output logic            halt
);

  logic        in_hs;
  inst_op_e    op;
  logic [31:0] imm;
  logic [31:0] inst;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;

  assign inst  = fetch.inst;
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // class from the opcode
  always_comb begin
    case (inst[6:0])
      opc_lui:     op = op_lui;
      opc_auipc:   op = op_auipc;
      opc_jal:     op = op_jal;
      opc_jalr:    op = op_jalr;
      opc_branch:  op = op_branch;
      opc_load:    op = op_load;
      opc_store:   op = op_store;
      opc_alu_imm: op = op_alu_imm;
      opc_alu:     op = op_alu;
      opc_system:  op = (inst == ebreak_inst) ? op_ebreak : op_system;
      default:     op = op_illegal;
    endcase
  end

  // immediate format by class
  always_comb begin
    case (op)
      op_lui, op_auipc:             imm = imm_u;
      op_jal:                       imm = imm_j;
      op_jalr, op_load, op_alu_imm: imm = imm_i;
      op_branch:                    imm = imm_b;
      op_store:                     imm = imm_s;
      default:                      imm = '0;
    endcase
  end

  // static next pc where only jal redirects
  assign npc = (op == op_jal) ? fetch.pc + imm : fetch.pc + 32'd4;

  assign fetch_ready = (~dec_valid | dec_ready) & ~halt;
  assign in_hs       = fetch_valid & fetch_ready;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      dec_valid <= 1'b0;
      halt      <= 1'b0;
    end else begin
      if (in_hs) begin
        dec_valid <= 1'b1;
        if (op == op_ebreak) begin
          halt <= 1'b1;
        end
      end else if (dec_ready) begin
        dec_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_hs) begin
      dec <= '{pc: fetch.pc, inst: inst, op: op, imm: imm};
    end
  end

endmodule

`default_nettype wire

// File: hdl/inst_mem.sv
`timescale 1ns/1ns
`default_nettype none

module inst_mem
  import fetch_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     rstn,
  input  wire prog_wr_t prog,
  input  wire ar_chan_t ar,
  input  wire logic     r_ready,
  output logic          ar_ready,
  output r_chan_t       r
);

  logic [63:0] mem [mem_words];

  logic                 pending_q;
  logic [63:0]          r_data_q;
  logic [mem_idx_w-1:0] rd_idx;
  logic                 ar_hs;
  logic                 r_hs;

  // index of 8-byte words wraps every 4 KiB
  assign rd_idx = ar.addr[mem_idx_w+2:3];

  assign ar_ready = ~pending_q;
  assign ar_hs    = ar.valid & ar_ready;
  assign r_hs     = r.valid & r_ready;

  assign r = '{valid: pending_q, data: r_data_q};

  // program load port
  always_ff @(posedge clk) begin
    if (prog.we) begin
      mem[prog.idx] <= prog.data;
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      r_data_q <= mem[rd_idx];
    end
  end

  // one read outstanding at a time
  always_ff @(posedge clk) begin
    if (!rstn) begin
      pending_q <= 1'b0;
    end else if (ar_hs) begin
      pending_q <= 1'b1;
    end else if (r_hs) begin
      pending_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: verification/tb_fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_fetch_top
  import fetch_pkg::*;
();

  localparam int clk_period     = 40;
  localparam int max_insts      = 2000;
  localparam int timeout_cycles = mem_words + 8 + max_insts * 8 + 64;

  logic      clk;
  logic      rstn;
  prog_wr_t  prog;
  logic      dec_ready;
  logic      dec_valid;
  dec_pkt_t  dec;
  logic      halt;
  perf_cnt_t perf;

  integer      seed = 53517;
  logic [63:0] model_mem [mem_words];
  dec_pkt_t    exp_q [$];
  dec_pkt_t    hold_pkt;
  dec_pkt_t    p;
  perf_cnt_t   exp_perf;
  logic [31:0] pc;
  logic [31:0] r;
  logic [63:0] word;
  logic        holding;
  logic        halt_case;
  int          eb_idx;
  int          n_run;
  int          n_taken;
  int          in_flight;

  // jal is drawn separately
  logic [6:0] legal_opc [9] = '{opc_lui, opc_auipc, opc_jalr, opc_branch, opc_load,
                                opc_store, opc_alu_imm, opc_alu, opc_system};

  fetch_top i_dut (
    .clk       (clk),
    .rstn      (rstn),
    .prog      (prog),
    .dec_ready (dec_ready),
    .dec_valid (dec_valid),
    .dec       (dec),
    .halt      (halt),
    .perf      (perf)
  );

  always #(clk_period / 2) clk = ~clk;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_dec(input dec_pkt_t got, input dec_pkt_t want);
    string msg;
    if (got !== want) begin
      msg = $sformatf("Error: dec got pc %h inst %h op %h imm %h",
                      got.pc, got.inst, got.op, got.imm);
      msg = {msg, $sformatf(", expected pc %h inst %h op %h imm %h",
                            want.pc, want.inst, want.op, want.imm)};
      report_failure(msg);
    end
  endtask

  // wait counters are only bounded below when at_least is set
  task automatic check_perf(input perf_cnt_t got, input perf_cnt_t want, input logic at_least);
    logic bad;
    if (at_least) begin
      bad = (got.fetches !== want.fetches) || (got.wait_mem < want.wait_mem) ||
            (got.wait_down < want.wait_down);
    end else begin
      bad = (got !== want);
    end
    if (bad) begin
      report_failure($sformatf("Error: perf got %h %h %h, expected %h %h %h",
                               got.fetches, got.wait_mem, got.wait_down,
                               want.fetches, want.wait_mem, want.wait_down));
    end
  endtask

  task automatic check_halt(input logic got, input logic want);
    if (got !== want) begin
      report_failure($sformatf("Error: halt got %h, expected %h", got, want));
    end
  endtask

  task automatic check_dec_valid(input logic got, input logic want);
    if (got !== want) begin
      report_failure($sformatf("Error: dec_valid got %h, expected %h", got, want));
    end
  endtask

  task automatic make_inst(output logic [31:0] inst);
    logic [31:0] bits;
    logic [31:0] sel;
    int          k;
    bits = $random(seed);
    sel  = $random(seed);
    k    = int'(sel[31:3] % 29'd9);
    // J field of a jal is always an even offset
    if (sel[2:0] == 3'd0) inst = {bits[31:7], opc_jal};
    else inst = {bits[31:7], legal_opc[k]};
  endtask

  function automatic dec_pkt_t model_decode(input logic [31:0] pc, input logic [31:0] inst);
    dec_pkt_t d;
    d.pc   = pc;
    d.inst = inst;
    case (inst[6:0])
      7'b0110111: d.op = op_lui;
      7'b0010111: d.op = op_auipc;
      7'b1101111: d.op = op_jal;
      7'b1100111: d.op = op_jalr;
      7'b1100011: d.op = op_branch;
      7'b0000011: d.op = op_load;
      7'b0100011: d.op = op_store;
      7'b0010011: d.op = op_alu_imm;
      7'b0110011: d.op = op_alu;
      7'b1110011: d.op = (inst == 32'h0010_0073) ? op_ebreak : op_system;
      default:    d.op = op_illegal;
    endcase
    case (d.op)
      op_lui, op_auipc: d.imm = {inst[31:12], 12'h000};
      op_jal: d.imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      op_jalr, op_load, op_alu_imm: d.imm = {{21{inst[31]}}, inst[30:20]};
      op_branch: d.imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      op_store: d.imm = {{21{inst[31]}}, inst[30:25], inst[11:7]};
      default: d.imm = '0;
    endcase
    return d;
  endfunction

  initial begin
    #(timeout_cycles * clk_period);
    report_failure("timed out waiting for the decoded instruction stream to finish");
  end

  initial begin
    clk       = 1'b0;
    rstn      = 1'b0;
    dec_ready = 1'b0;
    prog      = '0;
    holding   = 1'b0;
    n_taken   = 0;
    for (int i = 0; i < mem_words; i++) begin
      make_inst(r);
      word[31:0] = r;
      make_inst(r);
      word[63:32] = r;
      model_mem[i] = word;
    end
    // word 0 is the reset vector
    r      = $random(seed);
    eb_idx = 1 + int'(r[30:1] % 30'd511);
    if (r[0]) model_mem[eb_idx][63:32] = ebreak_inst;
    else model_mem[eb_idx][31:0] = ebreak_inst;

    // walk one past the limit to know what is still in flight
    pc = 32'h8000_0000;
    halt_case = 1'b0;
    while (!halt_case && exp_q.size() <= max_insts) begin
      word = model_mem[pc[mem_idx_w+2:3]];
      p    = model_decode(pc, pc[2] ? word[63:32] : word[31:0]);
      exp_q.push_back(p);
      halt_case = (p.op == op_ebreak);
      pc = (p.op == op_jal) ? pc + p.imm : pc + 32'd4;
    end
    halt_case = halt_case && (exp_q.size() <= max_insts);
    n_run     = halt_case ? exp_q.size() : max_insts;
    in_flight = halt_case ? 0 : ((exp_q[max_insts].op == op_ebreak) ? 1 : 2);

    for (int i = 0; i < mem_words; i++) begin
      @(negedge clk);
      prog = '{we: 1'b1, idx: i[mem_idx_w-1:0], data: model_mem[i]};
    end
    @(negedge clk);
    prog = '0;
    repeat (8) @(negedge clk);
    check_dec_valid(dec_valid, 1'b0);
    check_halt(halt, 1'b0);
    check_perf(perf, '0, 1'b0);
    rstn = 1'b1;

    while (n_taken < n_run) begin
      @(negedge clk);
      // stalled packet has to stay put
      if (holding) begin
        check_dec_valid(dec_valid, 1'b1);
        check_dec(dec, hold_pkt);
      end
      r         = $random(seed);
      dec_ready = (r[1:0] != 2'b00);
      holding   = dec_valid & ~dec_ready;
      hold_pkt  = dec;
      if (dec_valid && dec_ready) begin
        check_dec(dec, exp_q[n_taken]);
        check_halt(halt, exp_q[n_taken].op == op_ebreak);
        n_taken++;
      end
    end

    repeat (16) begin
      @(negedge clk);
      dec_ready = halt_case;
      if (halt_case) begin
        check_dec_valid(dec_valid, 1'b0);
        check_halt(halt, 1'b1);
      end
    end
    exp_perf.fetches   = n_run + in_flight;
    exp_perf.wait_mem  = n_run + in_flight;
    // every fetch but the first waits at least a cycle downstream
    exp_perf.wait_down = n_run + in_flight - 1;
    check_perf(perf, exp_perf, 1'b1);
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire
